/* compile.f */
verilog/husky_io_pkg.sv
verilog/husky_regs_pkg.sv
verilog/reg_bus_if.sv
verilog/usb_reg_ctrl.sv
verilog/userio_regs.sv
verilog/sample_fifo.sv
verilog/error_led.sv
verilog/husky_reg_top.sv
verif/husky_reg_chk.sv
verif/husky_reg_tb.sv

/* Bender.yml */
package:
  name: husky_reg

sources:
  - files:
      - verilog/husky_io_pkg.sv
      - verilog/husky_regs_pkg.sv
      - verilog/reg_bus_if.sv
      - verilog/usb_reg_ctrl.sv
      - verilog/userio_regs.sv
      - verilog/sample_fifo.sv
      - verilog/error_led.sv
      - verilog/husky_reg_top.sv
  - target: test
    files:
      - verif/husky_reg_chk.sv
      - verif/husky_reg_tb.sv

/* verif/husky_reg_tb.sv */
`default_nettype none

module husky_reg_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import husky_io_pkg::*;
   import husky_regs_pkg::*;

   typedef enum int {
      OP_WRITE, OP_READ, OP_READ_NEXT, OP_PUSH, OP_PIN, OP_ARM, OP_BLINK, OP_QUIET
   } op_t;

   localparam int MAX_STEPS   = 96;
   localparam int BLINK_LIMIT = 64;          // flash period is 16 cycles

   // pin selectors carried in the address column of OP_PIN
   localparam reg_addr_t PIN_USERIO     = 8'd0;
   localparam reg_addr_t PIN_USERIO_OE  = 8'd1;
   localparam reg_addr_t PIN_DATA_OE    = 8'd2;
   localparam reg_addr_t PIN_LED_ERROR  = 8'd3;
   localparam reg_addr_t PIN_LED_STATUS = 8'd4;

   logic      clk_usb_buf;
   logic      reset_i;
   reg_addr_t usb_addr;
   usb_byte_t usb_data_in;
   logic      usb_rdn_n;
   logic      usb_wrn_n;
   logic      usb_cen_n;
   logic      usb_alen_n;
   logic      sample_wr;
   usb_byte_t sample_data;
   logic      armed;
   usb_byte_t usb_data_out;
   logic      usb_data_oe;
   usb_byte_t userio;
   usb_byte_t userio_oe;
   logic      led_error;
   logic      led_status;

   string     step_name [MAX_STEPS];
   op_t       step_op   [MAX_STEPS];
   reg_addr_t step_addr [MAX_STEPS];
   usb_byte_t step_data [MAX_STEPS];
   usb_byte_t step_exp  [MAX_STEPS];
   int        n_steps;
   logic [15:0] lfsr_q;
   usb_byte_t model_q [$];                   // samples the FIFO should hold
   int        pass_cnt;
   int        fail_cnt;

   husky_reg_top dut_i (
      .clk_usb_buf   (clk_usb_buf),
      .reset_i       (reset_i),
      .usb_addr_i    (usb_addr),
      .usb_data_i    (usb_data_in),
      .usb_rdn_n_i   (usb_rdn_n),
      .usb_wrn_n_i   (usb_wrn_n),
      .usb_cen_n_i   (usb_cen_n),
      .usb_alen_n_i  (usb_alen_n),
      .sample_wr_i   (sample_wr),
      .sample_data_i (sample_data),
      .armed_i       (armed),
      .usb_data_o    (usb_data_out),
      .usb_data_oe_o (usb_data_oe),
      .userio_o      (userio),
      .userio_oe_o   (userio_oe),
      .led_error_o   (led_error),
      .led_status_o  (led_status)
   );

   bind usb_reg_ctrl husky_reg_chk chk_i (
      .clk_usb_buf   (clk_usb_buf),
      .reset_i       (reset_i),
      .rd_i          (bus.rd),
      .wr_i          (bus.wr),
      .usb_rdn_n_i   (usb_rdn_n_i),
      .usb_data_oe_i (usb_data_oe_o)
   );

   always #2 clk_usb_buf = ~clk_usb_buf;

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic usb_byte_t random_byte();
      usb_byte_t b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         b      = {b[6:0], lfsr_q[0]};       // one step per bit
      end
      return b;
   endfunction

   function automatic void add_step(input string name, input op_t op, input reg_addr_t addr,
                                    input usb_byte_t data, input usb_byte_t exp);
      step_name[n_steps] = name;
      step_op[n_steps]   = op;
      step_addr[n_steps] = addr;
      step_data[n_steps] = data;
      step_exp[n_steps]  = exp;
      n_steps++;
   endfunction

   function automatic void add_push(input string name);
      usb_byte_t s;
      s = random_byte();
      if (model_q.size() < FIFO_DEPTH) begin
         model_q.push_back(s);                // dropped when full
      end
      add_step(name, OP_PUSH, '0, s, '0);
   endfunction

   function automatic void add_pop(input string name);
      usb_byte_t e;
      e = '0;                                 // empty pop reads zero
      if (model_q.size() > 0) begin
         e = model_q.pop_front();
      end
      add_step(name, OP_READ, REG_FIFO_READ, '0, e);
   endfunction

   function automatic void build_table();
      n_steps = 0;
      add_step("reset data_oe", OP_PIN, PIN_DATA_OE, '0, '0);
      add_step("reset userio_oe", OP_PIN, PIN_USERIO_OE, '0, '0);
      add_step("reset led_error", OP_PIN, PIN_LED_ERROR, '0, '0);
      add_step("reset drive", OP_READ, REG_USERIO_DRIVE, '0, '0);
      add_step("reset dir", OP_READ, REG_USERIO_DIR, '0, '0);
      add_step("reset debug", OP_READ, REG_USERIO_DEBUG, '0, '0);
      add_step("reset fifo level", OP_READ, REG_FIFO_STATUS, '0, '0);
      add_step("reset errors", OP_READ, REG_ERRORS, '0, '0);
      add_step("write drive", OP_WRITE, REG_USERIO_DRIVE, 8'hA5, '0);
      add_step("write dir", OP_WRITE, REG_USERIO_DIR, 8'h3C, '0);
      add_step("read drive", OP_READ, REG_USERIO_DRIVE, '0, 8'hA5);
      add_step("read dir", OP_READ, REG_USERIO_DIR, '0, 8'h3C);
      add_step("pins drive", OP_PIN, PIN_USERIO, '0, 8'hA5);
      add_step("pins mask", OP_PIN, PIN_USERIO_OE, '0, 8'h3C);
      add_step("select debug fifo", OP_WRITE, REG_USERIO_DEBUG, {4'h0, DBG_FIFO}, '0);
      add_step("read debug", OP_READ, REG_USERIO_DEBUG, '0, {4'h0, DBG_FIFO});
      // full 0, empty 1, level 0
      add_step("pins debug fifo", OP_PIN, PIN_USERIO, '0, {1'b0, 1'b0, 1'b1, 5'd0});
      add_step("pins debug mask", OP_PIN, PIN_USERIO_OE, '0, 8'hFF);
      for (int i = 0; i < 5; i++) begin
         add_push($sformatf("push %0d", i));
      end
      add_step("status level 5", OP_READ, REG_FIFO_STATUS, '0, 8'd5);
      add_step("status flags 5", OP_READ_NEXT, REG_FIFO_STATUS, '0, 8'h00);
      add_step("pins debug level 5", OP_PIN, PIN_USERIO, '0, {1'b0, 1'b0, 1'b0, 5'd5});
      for (int i = 0; i < 5; i++) begin
         add_pop($sformatf("pop %0d", i));
      end
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         add_push($sformatf("fill %0d", i));
      end
      add_step("status level full", OP_READ, REG_FIFO_STATUS, '0, usb_byte_t'(FIFO_DEPTH));
      add_step("status flags full", OP_READ_NEXT, REG_FIFO_STATUS, '0, 8'h02);
      add_step("pins debug full", OP_PIN, PIN_USERIO, '0, {1'b0, 1'b1, 1'b0, 5'd16});
      add_step("select debug off", OP_WRITE, REG_USERIO_DEBUG, {4'h0, DBG_OFF}, '0);
      add_step("overflow flag", OP_READ, REG_ERRORS, '0, 8'h01 << ERR_OVERFLOW);
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         add_pop($sformatf("drain %0d", i));
      end
      add_pop("pop empty");
      add_step("both flags", OP_READ, REG_ERRORS, '0,
               (8'h01 << ERR_OVERFLOW) | (8'h01 << ERR_UNDERFLOW));
      add_step("led flashing", OP_BLINK, '0, '0, '0);
      add_step("clear errors", OP_WRITE, REG_CLEAR_ERRORS, 8'h5A, '0);
      add_step("errors cleared", OP_READ, REG_ERRORS, '0, 8'h00);
      add_step("led quiet", OP_QUIET, '0, '0, '0);
      add_step("arm", OP_ARM, '0, 8'h01, '0);
      add_step("status led armed", OP_PIN, PIN_LED_STATUS, '0, 8'h01);
      add_step("disarm", OP_ARM, '0, 8'h00, '0);
      add_step("status led idle", OP_PIN, PIN_LED_STATUS, '0, 8'h00);
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk_usb_buf);
   endtask

   task automatic address_phase(input reg_addr_t a);
      usb_cen_n  = 1'b0;
      usb_alen_n = 1'b0;
      usb_addr   = a;
      wait_cycles(1);
      usb_alen_n = 1'b1;
   endtask

   task automatic host_write(input reg_addr_t a, input usb_byte_t d);
      address_phase(a);
      usb_wrn_n   = 1'b0;
      usb_data_in = d;
      wait_cycles(3);
      usb_wrn_n = 1'b1;
      wait_cycles(1);
      usb_cen_n = 1'b1;
      wait_cycles(1);
   endtask

   // without a new address phase the burst position keeps counting
   task automatic host_read(input reg_addr_t a, input logic new_burst, output usb_byte_t d,
                            output logic oe);
      if (new_burst) begin
         address_phase(a);
      end
      usb_cen_n = 1'b0;
      usb_rdn_n = 1'b0;
      wait_cycles(6);
      d  = usb_data_out;
      oe = usb_data_oe;
      usb_rdn_n = 1'b1;
      wait_cycles(1);
      usb_cen_n = 1'b1;
      wait_cycles(1);
   endtask

   task automatic push_sample(input usb_byte_t d);
      sample_wr   = 1'b1;
      sample_data = d;
      wait_cycles(1);
      sample_wr = 1'b0;
      wait_cycles(1);
   endtask

   task automatic check_byte(input string name, input usb_byte_t exp, input usb_byte_t act);
      if (act === exp) begin
         pass_cnt++;
         $display("[OK] %s: 0x%02h", name, act);
      end else begin
         fail_cnt++;
         $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act === exp) begin
         pass_cnt++;
         $display("[OK] %s: %b", name, act);
      end else begin
         fail_cnt++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic expect_toggle(input string name);
      logic first;
      int   n;
      first = led_error;
      n     = 0;
      while (led_error === first && n < BLINK_LIMIT) begin
         wait_cycles(1);
         n++;
      end
      if (led_error === first) begin
         fail_cnt++;
         $display("%s: led_error_o did not toggle within %0d cycles", name, BLINK_LIMIT);
      end else begin
         pass_cnt++;
         $display("[OK] %s: toggled after %0d cycles", name, n);
      end
   endtask

   task automatic expect_quiet(input string name, input int cycles);
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         seen = seen | led_error;
         wait_cycles(1);
      end
      check_bit(name, 1'b0, seen);
   endtask

   task automatic run_step(input int i);
      usb_byte_t rd;
      logic      oe;
      case (step_op[i])
         OP_WRITE:     host_write(step_addr[i], step_data[i]);
         OP_PUSH:      push_sample(step_data[i]);
         OP_BLINK:     expect_toggle(step_name[i]);
         OP_QUIET:     expect_quiet(step_name[i], 40);
         OP_READ, OP_READ_NEXT: begin
            host_read(step_addr[i], step_op[i] == OP_READ, rd, oe);
            check_byte(step_name[i], step_exp[i], rd);
            check_bit($sformatf("%s data_oe", step_name[i]), 1'b1, oe);   // bus driven
         end
         OP_ARM: begin
            armed = step_data[i][0];
            wait_cycles(1);
         end
         default: begin
            case (step_addr[i])
               PIN_USERIO:    check_byte(step_name[i], step_exp[i], userio);
               PIN_USERIO_OE: check_byte(step_name[i], step_exp[i], userio_oe);
               PIN_DATA_OE:   check_bit(step_name[i], step_exp[i][0], usb_data_oe);
               PIN_LED_ERROR: check_bit(step_name[i], step_exp[i][0], led_error);
               default:       check_bit(step_name[i], step_exp[i][0], led_status);
            endcase
         end
      endcase
   endtask

   initial begin : watchdog
      #50us;
      $display("simulation did not finish within 50 us");
      $display("TEST FAILED");
      $finish;
   end

   initial begin : main
      clk_usb_buf = 1'b0;
      reset_i     = 1'b1;
      usb_addr    = '0;
      usb_data_in = '0;
      usb_rdn_n   = 1'b1;                     // bus idles high
      usb_wrn_n   = 1'b1;
      usb_cen_n   = 1'b1;
      usb_alen_n  = 1'b1;
      sample_wr   = 1'b0;
      sample_data = '0;
      armed       = 1'b0;
      lfsr_q      = 16'd1991;
      pass_cnt    = 0;
      fail_cnt    = 0;
      build_table();
      wait_cycles(4);
      reset_i = 1'b0;
      wait_cycles(1);
      for (int i = 0; i < n_steps; i++) begin
         run_step(i);
      end
      $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/husky_reg_chk.sv */
`default_nettype none

module husky_reg_chk (
   input wire clk_usb_buf,
   input wire reset_i,
   input wire rd_i,
   input wire wr_i,
   input wire usb_rdn_n_i,
   input wire usb_data_oe_i
);

   timeunit 1ns;
   timeprecision 1ps;

   strobe_excl_a: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      !(rd_i && wr_i))
      else $error("read and write strobes high in the same cycle");

   rd_single_a: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      rd_i |=> !rd_i)
      else $error("read strobe longer than one cycle");

   wr_single_a: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      wr_i |=> !wr_i)
      else $error("write strobe longer than one cycle");

   // enable only follows a sampled low rdn
   oe_idle_a: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      usb_rdn_n_i |=> !usb_data_oe_i)
      else $error("data output enabled after rdn was high");

endmodule

`default_nettype wire

/* verilog/husky_reg_top.sv */
`default_nettype none

module husky_reg_top (
   input  wire                            clk_usb_buf,
   input  wire                            reset_i,
   input  wire husky_io_pkg::reg_addr_t   usb_addr_i,
   input  wire husky_io_pkg::usb_byte_t   usb_data_i,
   input  wire                            usb_rdn_n_i,
   input  wire                            usb_wrn_n_i,
   input  wire                            usb_cen_n_i,
   input  wire                            usb_alen_n_i,
   input  wire                            sample_wr_i,
   input  wire husky_io_pkg::usb_byte_t   sample_data_i,
   input  wire                            armed_i,
   output husky_io_pkg::usb_byte_t        usb_data_o,
   output logic                           usb_data_oe_o,
   output husky_io_pkg::usb_byte_t        userio_o,
   output husky_io_pkg::usb_byte_t        userio_oe_o,
   output logic                           led_error_o,
   output logic                           led_status_o
);

   import husky_io_pkg::*;

   usb_byte_t   rdata_userio;
   usb_byte_t   rdata_fifo;
   usb_byte_t   rdata_err;
   usb_byte_t   err_flags;
   fifo_count_t fifo_level;
   logic        fifo_empty;
   logic        fifo_full;
   logic        overflow;
   logic        underflow;

   reg_bus_if bus ();

   usb_reg_ctrl u_usb_reg_ctrl (
      .clk_usb_buf    (clk_usb_buf),
      .reset_i        (reset_i),
      .usb_addr_i     (usb_addr_i),
      .usb_data_i     (usb_data_i),
      .usb_rdn_n_i    (usb_rdn_n_i),
      .usb_wrn_n_i    (usb_wrn_n_i),
      .usb_cen_n_i    (usb_cen_n_i),
      .usb_alen_n_i   (usb_alen_n_i),
      .rdata_userio_i (rdata_userio),
      .rdata_fifo_i   (rdata_fifo),
      .rdata_err_i    (rdata_err),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o),
      .bus            (bus)
   );

   userio_regs u_userio_regs (
      .clk_usb_buf    (clk_usb_buf),
      .reset_i        (reset_i),
      .bus            (bus),
      .usb_rdn_n_i    (usb_rdn_n_i),
      .usb_wrn_n_i    (usb_wrn_n_i),
      .usb_cen_n_i    (usb_cen_n_i),
      .usb_addr_i     (usb_addr_i),
      .fifo_level_i   (fifo_level),
      .fifo_empty_i   (fifo_empty),
      .fifo_full_i    (fifo_full),
      .err_flags_i    (err_flags),
      .rdata_o        (rdata_userio),
      .userio_o       (userio_o),
      .userio_oe_o    (userio_oe_o)
   );

   sample_fifo u_sample_fifo (
      .clk_usb_buf    (clk_usb_buf),
      .reset_i        (reset_i),
      .bus            (bus),
      .sample_wr_i    (sample_wr_i),
      .sample_data_i  (sample_data_i),
      .rdata_o        (rdata_fifo),
      .fifo_level_o   (fifo_level),
      .fifo_empty_o   (fifo_empty),
      .fifo_full_o    (fifo_full),
      .overflow_o     (overflow),
      .underflow_o    (underflow)
   );

   error_led u_error_led (
      .clk_usb_buf    (clk_usb_buf),
      .reset_i        (reset_i),
      .bus            (bus),
      .overflow_i     (overflow),
      .underflow_i    (underflow),
      .armed_i        (armed_i),
      .rdata_o        (rdata_err),
      .err_flags_o    (err_flags),
      .led_error_o    (led_error_o),
      .led_status_o   (led_status_o)
   );

endmodule

`default_nettype wire

/* verilog/error_led.sv */
`default_nettype none

module error_led (
   input  wire                            clk_usb_buf,
   input  wire                            reset_i,
   reg_bus_if.periph                      bus,
   input  wire                            overflow_i,
   input  wire                            underflow_i,
   input  wire                            armed_i,
   output husky_io_pkg::usb_byte_t        rdata_o,
   output husky_io_pkg::usb_byte_t        err_flags_o,
   output logic                           led_error_o,
   output logic                           led_status_o
);

   import husky_io_pkg::*;
   import husky_regs_pkg::*;

   usb_byte_t        err_q;
   logic [FLASH_BIT:0] flash_cnt;
   logic             flash;
   logic             any_err;
   logic             clr;

   assign clr = bus.wr && (bus.addr == REG_CLEAR_ERRORS);

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         err_q <= '0;
      end else begin
         if (clr) begin
            err_q <= '0;
         end
         if (overflow_i) begin
            err_q[ERR_OVERFLOW] <= 1'b1;    // a new event beats a clear
         end
         if (underflow_i) begin
            err_q[ERR_UNDERFLOW] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         flash_cnt <= '0;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   assign flash        = flash_cnt[FLASH_BIT];
   assign any_err      = |err_q;
   assign err_flags_o  = err_q;
   assign rdata_o      = (bus.addr == REG_ERRORS) ? err_q : '0;

   // both LEDs blink together on any error
   assign led_error_o  = any_err ? flash : 1'b0;
   assign led_status_o = any_err ? flash : armed_i;

endmodule

`default_nettype wire

/* verilog/sample_fifo.sv */
`default_nettype none

module sample_fifo (
   input  wire                            clk_usb_buf,
   input  wire                            reset_i,
   reg_bus_if.periph                      bus,
   input  wire                            sample_wr_i,
   input  wire husky_io_pkg::usb_byte_t   sample_data_i,
   output husky_io_pkg::usb_byte_t        rdata_o,
   output husky_io_pkg::fifo_count_t      fifo_level_o,
   output logic                           fifo_empty_o,
   output logic                           fifo_full_o,
   output logic                           overflow_o,
   output logic                           underflow_o
);

   import husky_io_pkg::*;
   import husky_regs_pkg::*;

   usb_byte_t             mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   fifo_count_t           level_q;
   logic                  pop_req;     // host read of the data address
   logic                  push;
   logic                  pop;

   assign fifo_level_o = level_q;
   assign fifo_empty_o = (level_q == '0);
   assign fifo_full_o  = (level_q == fifo_count_t'(FIFO_DEPTH));

   assign pop_req = bus.rd && (bus.addr == REG_FIFO_READ);
   assign push    = sample_wr_i & ~fifo_full_o;    // blocked when full
   assign pop     = pop_req & ~fifo_empty_o;

   assign overflow_o  = sample_wr_i & fifo_full_o;
   assign underflow_o = pop_req & fifo_empty_o;

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wr_ptr] <= sample_data_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_q <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at FIFO_DEPTH
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: ;
         endcase
      end
   end

   // head of the FIFO, or status by burst position
   always_comb begin
      rdata_o = '0;
      if (bus.addr == REG_FIFO_READ) begin
         rdata_o = fifo_empty_o ? '0 : mem[rd_ptr];
      end else if (bus.addr == REG_FIFO_STATUS) begin
         case (bus.bytecnt)
            bytecnt_t'(0): rdata_o = usb_byte_t'(level_q);
            bytecnt_t'(1): rdata_o = {6'b0, fifo_full_o, fifo_empty_o};
            default:       rdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/userio_regs.sv */
`default_nettype none

module userio_regs (
   input  wire                            clk_usb_buf,
   input  wire                            reset_i,
   reg_bus_if.periph                      bus,
   input  wire                            usb_rdn_n_i,
   input  wire                            usb_wrn_n_i,
   input  wire                            usb_cen_n_i,
   input  wire husky_io_pkg::reg_addr_t   usb_addr_i,
   input  wire husky_io_pkg::fifo_count_t fifo_level_i,
   input  wire                            fifo_empty_i,
   input  wire                            fifo_full_i,
   input  wire husky_io_pkg::usb_byte_t   err_flags_i,
   output husky_io_pkg::usb_byte_t        rdata_o,
   output husky_io_pkg::usb_byte_t        userio_o,
   output husky_io_pkg::usb_byte_t        userio_oe_o
);

   import husky_io_pkg::*;
   import husky_regs_pkg::*;

   logic [USERIO_WIDTH-1:0] drive_q;    // pin data
   logic [USERIO_WIDTH-1:0] dir_q;      // pin drive mask
   logic [3:0]              dbg_sel_q;
   usb_byte_t               dbg_byte;

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         drive_q   <= '0;
         dir_q     <= '0;
         dbg_sel_q <= DBG_OFF;
      end else if (bus.wr) begin
         case (bus.addr)
            REG_USERIO_DRIVE: drive_q   <= bus.wdata;
            REG_USERIO_DIR:   dir_q     <= bus.wdata;
            REG_USERIO_DEBUG: dbg_sel_q <= bus.wdata[3:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      case (bus.addr)
         REG_USERIO_DRIVE: rdata_o = drive_q;
         REG_USERIO_DIR:   rdata_o = dir_q;
         REG_USERIO_DEBUG: rdata_o = {4'b0, dbg_sel_q};
         default:          rdata_o = '0;
      endcase
   end

   // internal status put on the header
   always_comb begin
      case (dbg_sel_q)
         DBG_USB:    dbg_byte = {usb_rdn_n_i, usb_wrn_n_i, usb_cen_n_i, usb_addr_i[4:0]};
         DBG_FIFO:   dbg_byte = {1'b0, fifo_full_i, fifo_empty_i, fifo_level_i};
         DBG_ERRORS: dbg_byte = err_flags_i;
         default:    dbg_byte = '0;
      endcase
   end

   always_comb begin
      if (dbg_sel_q == DBG_OFF) begin
         userio_o    = drive_q;
         userio_oe_o = dir_q;
      end else begin
         userio_o    = dbg_byte;
         userio_oe_o = '1;           // debug drives every pin
      end
   end

endmodule

`default_nettype wire

/* verilog/usb_reg_ctrl.sv */
`default_nettype none

module usb_reg_ctrl (
   input  wire                            clk_usb_buf,
   input  wire                            reset_i,
   input  wire husky_io_pkg::reg_addr_t   usb_addr_i,
   input  wire husky_io_pkg::usb_byte_t   usb_data_i,
   input  wire                            usb_rdn_n_i,
   input  wire                            usb_wrn_n_i,
   input  wire                            usb_cen_n_i,
   input  wire                            usb_alen_n_i,
   input  wire husky_io_pkg::usb_byte_t   rdata_userio_i,
   input  wire husky_io_pkg::usb_byte_t   rdata_fifo_i,
   input  wire husky_io_pkg::usb_byte_t   rdata_err_i,
   output husky_io_pkg::usb_byte_t        usb_data_o,
   output logic                           usb_data_oe_o,
   reg_bus_if.ctrl                        bus
);

   import husky_io_pkg::*;

   usb_byte_t rdata_all;     // all blocks are zero off their own addresses
   logic      rdn_q;         // rdn from the previous edge
   logic      wrn_q;
   logic      rd_fall;
   logic      wr_fall;

   assign rdata_all = rdata_userio_i | rdata_fifo_i | rdata_err_i;

   // falling edge seen on this sample, only while selected
   assign rd_fall = rdn_q & ~usb_rdn_n_i & ~usb_cen_n_i;
   assign wr_fall = wrn_q & ~usb_wrn_n_i & ~usb_cen_n_i & ~rd_fall;   // read wins a tie

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         rdn_q         <= 1'b1;      // bus idle level
         wrn_q         <= 1'b1;
         bus.rd        <= 1'b0;
         bus.wr        <= 1'b0;
         usb_data_oe_o <= 1'b0;
      end else begin
         rdn_q         <= usb_rdn_n_i;
         wrn_q         <= usb_wrn_n_i;
         bus.rd        <= rd_fall;
         bus.wr        <= wr_fall;
         usb_data_oe_o <= ~usb_cen_n_i & ~usb_rdn_n_i;
      end
   end

   // address phase clears the burst position, each access advances it
   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         bus.addr    <= '0;
         bus.bytecnt <= '0;
      end else if (!usb_cen_n_i && !usb_alen_n_i) begin
         bus.addr    <= usb_addr_i;
         bus.bytecnt <= '0;
      end else if (bus.rd || bus.wr) begin
         bus.bytecnt <= bus.bytecnt + 1'b1;   // after the strobe cycle
      end
   end

   // write byte is taken on the same edge that sees wrn low
   always_ff @(posedge clk_usb_buf) begin
      if (wr_fall) begin
         bus.wdata <= usb_data_i;
      end
   end

   // capture reply on the strobe cycle, holds for the rest of the access
   always_ff @(posedge clk_usb_buf) begin
      if (bus.rd) begin
         usb_data_o <= rdata_all;
      end
   end

endmodule

`default_nettype wire

/* verilog/reg_bus_if.sv */
`default_nettype none

interface reg_bus_if;

   husky_io_pkg::reg_addr_t addr;      // latched register address
   husky_io_pkg::bytecnt_t  bytecnt;   // byte within the burst
   husky_io_pkg::usb_byte_t wdata;     // write byte
   logic                    rd;        // one cycle per host read
   logic                    wr;        // one cycle per host write

   modport ctrl (
      output addr,
      output bytecnt,
      output wdata,
      output rd,
      output wr
   );

   modport periph (
      input addr,
      input bytecnt,
      input wdata,
      input rd,
      input wr
   );

endinterface

`default_nettype wire

/* verilog/husky_regs_pkg.sv */
`default_nettype none

package husky_regs_pkg;

   // user I/O header
   localparam logic [7:0] REG_USERIO_DRIVE = 8'h10;
   localparam logic [7:0] REG_USERIO_DIR   = 8'h11;   // 1 = pin driven
   localparam logic [7:0] REG_USERIO_DEBUG = 8'h12;   // select in low nibble

   // sample FIFO
   localparam logic [7:0] REG_FIFO_READ    = 8'h03;   // read pops one sample
   localparam logic [7:0] REG_FIFO_STATUS  = 8'h20;   // byte 0 level, byte 1 flags

   // error flags
   localparam logic [7:0] REG_ERRORS       = 8'h21;   // read only
   localparam logic [7:0] REG_CLEAR_ERRORS = 8'h22;   // any write clears

   // debug select codes
   localparam logic [3:0] DBG_OFF    = 4'd0;
   localparam logic [3:0] DBG_USB    = 4'd1;
   localparam logic [3:0] DBG_FIFO   = 4'd2;
   localparam logic [3:0] DBG_ERRORS = 4'd3;

   // bit positions in the error register
   localparam int ERR_OVERFLOW  = 0;
   localparam int ERR_UNDERFLOW = 1;

endpackage

`default_nettype wire

/* verilog/husky_io_pkg.sv */
`default_nettype none

package husky_io_pkg;

   // host bus widths
   typedef logic [7:0] usb_byte_t;
   typedef logic [7:0] reg_addr_t;

   localparam int USERIO_WIDTH = 8;        // header pins

   // byte position within one address burst
   localparam int BYTECNT_SIZE = 7;
   typedef logic [BYTECNT_SIZE-1:0] bytecnt_t;

   // sample FIFO geometry
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   typedef logic [FIFO_PTR_W:0] fifo_count_t;   // one extra bit to hold FIFO_DEPTH

   // free-running counter bit used for the LED flash
   localparam int FLASH_BIT = 3;

endpackage

`default_nettype wire
